/* rtl/rv_pkg.sv */
// ################################################
// RV32I core shared definitions
// Widths, opcodes, ALU selectors, instruction
// formats and the control/flag bundles
// ################################################

package rv_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_pc = '0;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_e;

  // Encoding follows funct3 of OP/OP-IMM
  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_srl  = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_s;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_s;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_s;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_s;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_s;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_s;

  // One instruction word, six views
  typedef union packed {
    r_fmt_s r;
    i_fmt_s i;
    s_fmt_s s;
    b_fmt_s b;
    u_fmt_s u;
    j_fmt_s j;
  } instr_u;

  typedef struct packed {
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
  } dec_s;

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry_out;
    logic overflow;
  } flags_s;

  typedef struct packed {
    logic       alua_src;
    logic       alub_src;
    alu_op_e    alu_op;
    logic       sub;
    logic       arithmetic;
    logic       alupc_src;
    logic       pc_src;
    logic       pc_en;
    logic [1:0] wr_reg_src;
    logic       wr_reg_en;
    logic       ir_en;
    logic       mem_addr_src;
    logic       mem_wr;
  } ctrl_s;

endpackage

/* rtl/rv_alu.sv */
// ################################################
// 32-bit ALU
// Add/sub, shifts, compares and logic, with
// flags taken from the adder path
// ################################################

`timescale 1ns/1ns

module rv_alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_e         alu_op,
  input  logic                    sub,
  input  logic                    arithmetic,
  output logic [rv_pkg::xlen-1:0] y,
  output rv_pkg::flags_s          flags
);

  logic [rv_pkg::xlen-1:0] b_eff;
  logic [rv_pkg::xlen-1:0] sum;
  logic                    carry;
  logic [4:0]              shamt;

  // Subtract as a + ~b + 1
  assign b_eff = sub ? ~b : b;
  assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{rv_pkg::xlen{1'b0}}, sub};
  assign shamt = b[4:0];

  always_comb begin
    flags.zero      = (sum == '0);
    flags.negative  = sum[rv_pkg::xlen-1];
    flags.carry_out = carry;
    flags.overflow  = (a[rv_pkg::xlen-1] == b_eff[rv_pkg::xlen-1]) &&
                      (sum[rv_pkg::xlen-1] != a[rv_pkg::xlen-1]);
  end

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  y = sum;
      rv_pkg::alu_sll:  y = a << shamt;
      // Compares rely on sub being set
      rv_pkg::alu_slt:  y = {{(rv_pkg::xlen-1){1'b0}}, flags.negative ^ flags.overflow};
      rv_pkg::alu_sltu: y = {{(rv_pkg::xlen-1){1'b0}}, ~carry};
      rv_pkg::alu_xor:  y = a ^ b;
      rv_pkg::alu_srl: begin
        // Arithmetic variant fills with the sign bit
        if (arithmetic) begin
          y = $signed(a) >>> shamt;
        end else begin
          y = a >> shamt;
        end
      end
      rv_pkg::alu_or:   y = a | b;
      default:          y = a & b;
    endcase
  end

endmodule

/* rtl/rv_imm_ext.sv */
// ################################################
// Immediate extender
// Picks the format immediate by opcode and
// sign-extends it to the data width
// ################################################

`timescale 1ns/1ns

module rv_imm_ext (
  input  rv_pkg::instr_u          instr,
  output logic [rv_pkg::xlen-1:0] imm
);

  always_comb begin
    case (instr.r.opcode)
      rv_pkg::opc_lui, rv_pkg::opc_auipc:
        imm = {instr.u.imm_31_12, 12'b0};
      rv_pkg::opc_jal:
        imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
               instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      rv_pkg::opc_branch:
        imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
               instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      rv_pkg::opc_store:
        imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      // JALR, loads and OP-IMM
      default:
        imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    endcase
  end

endmodule

/* rtl/rv_reg_file.sv */
// ################################################
// Integer register file
// 31 registers, two async read ports and one
// write port; x0 always reads zero
// ################################################

`timescale 1ns/1ns

module rv_reg_file (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    wr_en,
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  input  logic [4:0]              rd_addr,
  input  logic [rv_pkg::xlen-1:0] rd_data_in,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data
);

  logic [rv_pkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data_in;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

/* rtl/rv_dataflow.sv */
// ################################################
// RV32I dataflow
// PC and instruction registers, register file,
// ALU, operand/writeback muxes, PC adders and
// the memory address mux
// ################################################

`timescale 1ns/1ns

module rv_dataflow (
  input  logic                    clock,
  input  logic                    rst_n,
  input  rv_pkg::ctrl_s           ctrl,
  input  logic [rv_pkg::xlen-1:0] rd_data,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] wr_data,
  output rv_pkg::dec_s            dec,
  output rv_pkg::flags_s          flags
);

  rv_pkg::instr_u          ir;
  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] next_pc;
  logic [4:0]              rs1_addr;
  logic [rv_pkg::xlen-1:0] rs1;
  logic [rv_pkg::xlen-1:0] rs2;
  logic [rv_pkg::xlen-1:0] rd;
  logic [rv_pkg::xlen-1:0] imm;
  logic [rv_pkg::xlen-1:0] alu_a;
  logic [rv_pkg::xlen-1:0] alu_b;
  logic [rv_pkg::xlen-1:0] alu_y;
  logic [rv_pkg::xlen-1:0] pc_plus_4;
  logic [rv_pkg::xlen-1:0] pc_plus_imm;
  logic [rv_pkg::xlen-1:0] jump_target;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= rv_pkg::reset_pc;
      ir <= '0;
    end else begin
      if (ctrl.pc_en) begin
        pc <= next_pc;
      end
      if (ctrl.ir_en) begin
        ir <= rd_data;
      end
    end
  end

  // LUI reads x0 so the ALU computes 0 + imm
  assign rs1_addr = (ir.r.opcode == rv_pkg::opc_lui) ? 5'd0 : ir.r.rs1;

  rv_reg_file u_reg_file (
    .clock     (clock),
    .rst_n     (rst_n),
    .wr_en     (ctrl.wr_reg_en),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (ir.r.rs2),
    .rd_addr   (ir.r.rd),
    .rd_data_in(rd),
    .rs1_data  (rs1),
    .rs2_data  (rs2)
  );

  rv_imm_ext u_imm_ext (
    .instr(ir),
    .imm  (imm)
  );

  assign alu_a = ctrl.alua_src ? pc : rs1;
  assign alu_b = ctrl.alub_src ? imm : rs2;

  rv_alu u_alu (
    .a         (alu_a),
    .b         (alu_b),
    .alu_op    (ctrl.alu_op),
    .sub       (ctrl.sub),
    .arithmetic(ctrl.arithmetic),
    .y         (alu_y),
    .flags     (flags)
  );

  // Sequential and target adders
  assign pc_plus_4   = pc + rv_pkg::xlen'(4);
  assign pc_plus_imm = (ctrl.alupc_src ? rs1 : pc) + imm;
  // JALR drops bit 0 of its target
  assign jump_target = {pc_plus_imm[rv_pkg::xlen-1:1], pc_plus_imm[0] & ~ctrl.alupc_src};
  assign next_pc     = ctrl.pc_src ? jump_target : pc_plus_4;

  always_comb begin
    case (ctrl.wr_reg_src)
      2'd0:    rd = alu_y;
      2'd1:    rd = rd_data;
      2'd2:    rd = pc_plus_4;
      default: rd = pc_plus_imm;
    endcase
  end

  assign mem_addr = ctrl.mem_addr_src ? alu_y : pc;
  assign wr_data  = rs2;

  assign dec = '{opcode: ir.r.opcode, funct3: ir.r.funct3, funct7: ir.r.funct7};

  a_pc_aligned: assert property (@(posedge clock) disable iff (!rst_n)
    ctrl.pc_en |-> (next_pc[1:0] == 2'b00));

endmodule

/* rtl/rv_control.sv */
// ################################################
// RV32I multicycle control unit
// FETCH/DECODE/EXECUTE/MEMORY/HALT state machine
// driving the dataflow control bundle
// ################################################

`timescale 1ns/1ns

module rv_control (
  input  logic           clock,
  input  logic           rst_n,
  input  rv_pkg::dec_s   dec,
  input  rv_pkg::flags_s flags,
  output rv_pkg::ctrl_s  ctrl,
  output logic           halted
);

  typedef enum logic [2:0] {
    s_fetch,
    s_decode,
    s_execute,
    s_memory,
    s_halt
  } state_e;

  state_e state;
  state_e state_next;
  logic   legal;
  logic   taken;
  logic   lt;

  always_comb begin
    case (dec.opcode)
      rv_pkg::opc_lui, rv_pkg::opc_auipc, rv_pkg::opc_jal, rv_pkg::opc_jalr,
      rv_pkg::opc_branch, rv_pkg::opc_load, rv_pkg::opc_store,
      rv_pkg::opc_op_imm, rv_pkg::opc_op: legal = 1'b1;
      default:                            legal = 1'b0;
    endcase
  end

  // Branch compare on rs1 - rs2
  assign lt = flags.negative ^ flags.overflow;

  always_comb begin
    case (dec.funct3)
      3'b000:  taken = flags.zero;
      3'b001:  taken = ~flags.zero;
      3'b100:  taken = lt;
      3'b101:  taken = ~lt;
      3'b110:  taken = ~flags.carry_out;
      3'b111:  taken = flags.carry_out;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (state)
      s_fetch:   state_next = s_decode;
      s_decode:  state_next = legal ? s_execute : s_halt;
      s_execute: state_next = (dec.opcode == rv_pkg::opc_load) ? s_memory : s_fetch;
      s_memory:  state_next = s_fetch;
      default:   state_next = s_halt;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_fetch;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = rv_pkg::alu_add;
    case (state)
      s_fetch: ctrl.ir_en = 1'b1;
      s_execute: begin
        case (dec.opcode)
          rv_pkg::opc_lui: begin
            ctrl.alub_src  = 1'b1;
            ctrl.wr_reg_en = 1'b1;
            ctrl.pc_en     = 1'b1;
          end
          rv_pkg::opc_auipc: begin
            ctrl.alua_src   = 1'b1;
            ctrl.alub_src   = 1'b1;
            ctrl.wr_reg_src = 2'd3;
            ctrl.wr_reg_en  = 1'b1;
            ctrl.pc_en      = 1'b1;
          end
          rv_pkg::opc_jal, rv_pkg::opc_jalr: begin
            ctrl.alub_src   = 1'b1;
            ctrl.alupc_src  = (dec.opcode == rv_pkg::opc_jalr);
            ctrl.pc_src     = 1'b1;
            ctrl.wr_reg_src = 2'd2;
            ctrl.wr_reg_en  = 1'b1;
            ctrl.pc_en      = 1'b1;
          end
          rv_pkg::opc_branch: begin
            ctrl.sub    = 1'b1;
            ctrl.pc_src = taken;
            ctrl.pc_en  = 1'b1;
          end
          rv_pkg::opc_store: begin
            ctrl.alub_src     = 1'b1;
            ctrl.mem_addr_src = 1'b1;
            ctrl.mem_wr       = 1'b1;
            ctrl.pc_en        = 1'b1;
          end
          rv_pkg::opc_op_imm, rv_pkg::opc_op: begin
            ctrl.alub_src   = (dec.opcode == rv_pkg::opc_op_imm);
            ctrl.alu_op     = rv_pkg::alu_op_e'(dec.funct3);
            // SUB only for OP; SLT/SLTU always compare by subtraction
            ctrl.sub        = ((dec.opcode == rv_pkg::opc_op) && dec.funct3 == 3'b000 &&
                               dec.funct7[5]) || dec.funct3 == 3'b010 ||
                              dec.funct3 == 3'b011;
            ctrl.arithmetic = (dec.funct3 == 3'b101) && dec.funct7[5];
            ctrl.wr_reg_en  = 1'b1;
            ctrl.pc_en      = 1'b1;
          end
          default: ;
        endcase
      end
      s_memory: begin
        ctrl.alub_src     = 1'b1;
        ctrl.mem_addr_src = 1'b1;
        ctrl.wr_reg_src   = 2'd1;
        ctrl.wr_reg_en    = 1'b1;
        ctrl.pc_en        = 1'b1;
      end
      default: ;
    endcase
  end

  assign halted = (state == s_halt);

  a_no_wr_during_fetch: assert property (@(posedge clock) disable iff (!rst_n)
    !(ctrl.mem_wr && ctrl.ir_en));

  a_halt_sticky: assert property (@(posedge clock) disable iff (!rst_n)
    halted |=> halted);

endmodule

/* rtl/rv_core.sv */
// ################################################
// RV32I multicycle core top level
// Control unit plus dataflow on one unified
// memory port
// ################################################

`timescale 1ns/1ns

module rv_core (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic [rv_pkg::xlen-1:0] rd_data,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] wr_data,
  output logic                    mem_wr,
  output logic                    halted
);

  rv_pkg::ctrl_s  ctrl;
  rv_pkg::dec_s   dec;
  rv_pkg::flags_s flags;

  rv_control u_control (
    .clock (clock),
    .rst_n (rst_n),
    .dec   (dec),
    .flags (flags),
    .ctrl  (ctrl),
    .halted(halted)
  );

  rv_dataflow u_dataflow (
    .clock   (clock),
    .rst_n   (rst_n),
    .ctrl    (ctrl),
    .rd_data (rd_data),
    .mem_addr(mem_addr),
    .wr_data (wr_data),
    .dec     (dec),
    .flags   (flags)
  );

  assign mem_wr = ctrl.mem_wr;

endmodule

/* dv/tb_checker.sv */
// ################################################
// Store checker for the RV32I core testbench
// Compares memory writes in order against the
// expected list and reports per test
// ################################################

`timescale 1ns/1ns

module tb_checker (
  input logic                    clock,
  input logic                    rst_n,
  input logic                    mem_wr,
  input logic [rv_pkg::xlen-1:0] mem_addr,
  input logic [rv_pkg::xlen-1:0] wr_data,
  input logic                    halted
);

  logic [rv_pkg::xlen-1:0] exp_addr [$];
  logic [rv_pkg::xlen-1:0] exp_data [$];
  logic [8*16-1:0]         test_name;
  bit                      active;
  bit                      seen_halt;
  int                      errors;
  int                      stores;
  int                      tests_run;
  int                      failed_tests;

  initial begin
    active = 1'b0;
    seen_halt = 1'b0;
    errors = 0;
    stores = 0;
    tests_run = 0;
    failed_tests = 0;
  end

  task automatic start_test(input logic [8*16-1:0] name);
    test_name = name;
    exp_addr.delete();
    exp_data.delete();
    errors = 0;
    stores = 0;
    seen_halt = 1'b0;
    active = 1'b1;
  endtask

  task automatic add_expected(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch: test %0s store %0d %0s expected %h actual %h",
               test_name, stores, what, expected, actual);
      errors++;
    end
  endtask

  // Sampled on the edge where the memory takes the write
  always @(posedge clock) begin
    if (!rst_n) begin
      // Reset is the only legal way out of halt
      seen_halt = 1'b0;
    end else if (active) begin
      if (mem_wr) begin
        stores++;
        if (exp_addr.size() == 0) begin
          $display("error: test %0s made an unexpected store of %h to %h",
                   test_name, wr_data, mem_addr);
          errors++;
        end else begin
          check_value("address", exp_addr.pop_front(), mem_addr);
          check_value("data", exp_data.pop_front(), wr_data);
        end
      end
      if (halted) begin
        seen_halt = 1'b1;
      end else if (seen_halt) begin
        $display("error: test %0s left the halted state without a reset", test_name);
        errors++;
      end
    end
  end

  task automatic finish_test(input bit hung);
    active = 1'b0;
    tests_run++;
    if (hung) begin
      errors++;
    end
    if (exp_addr.size() != 0) begin
      $display("error: test %0s halted with %0d expected stores missing",
               test_name, exp_addr.size());
      errors++;
    end
    if (errors == 0) begin
      $display("test %0s: pass, %0d stores checked", test_name, stores);
    end else begin
      $display("test %0s: fail, %0d errors", test_name, errors);
      failed_tests++;
    end
  endtask

  task automatic report_counts();
    $display("tests run: %0d, passed: %0d, failed: %0d",
             tests_run, tests_run - failed_tests, failed_tests);
  endtask

endmodule

/* dv/tb_top.sv */
// ################################################
// Testbench top for the RV32I multicycle core
// Unified memory model, program loader, reset
// sequencing and a per-test cycle limit
// ################################################

`timescale 1ns/1ns

module tb_top;

  logic                    clock;
  logic                    rst_n;
  logic [rv_pkg::xlen-1:0] rd_data;
  logic [rv_pkg::xlen-1:0] mem_addr;
  logic [rv_pkg::xlen-1:0] wr_data;
  logic                    mem_wr;
  logic                    halted;

  // 1024 words, word index from mem_addr / 4
  logic [rv_pkg::xlen-1:0] mem [0:1023];
  logic [8*16-1:0]         test_name;

  initial clock = 1'b0;
  always #4 clock = ~clock;

  rv_core UUT (
    .clock   (clock),
    .rst_n   (rst_n),
    .rd_data (rd_data),
    .mem_addr(mem_addr),
    .wr_data (wr_data),
    .mem_wr  (mem_wr),
    .halted  (halted)
  );

  tb_checker u_checker (
    .clock   (clock),
    .rst_n   (rst_n),
    .mem_wr  (mem_wr),
    .mem_addr(mem_addr),
    .wr_data (wr_data),
    .halted  (halted)
  );

  // Combinational read port
  assign rd_data = mem[mem_addr[11:2]];

  always @(posedge clock) begin
    if (mem_wr) begin
      mem[mem_addr[11:2]] <= wr_data;
    end
  end

  task automatic fill_memory();
    for (int i = 0; i < 1024; i++) begin
      // Low byte 8'hff decodes as an illegal opcode, so a stray jump halts
      mem[i] = {i[23:0], 8'hff};
    end
  endtask

  // Release reset, then wait for halt within 4 cycles per instruction
  task automatic run_test(input int bound, output bit hung);
    int limit;
    int cycles;
    limit = 4 * bound + 20;
    cycles = 0;
    repeat (3) @(posedge clock);
    rst_n <= 1'b1;
    while (!halted && cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    hung = !halted;
    if (hung) begin
      $display("error: test %0s did not halt within %0d cycles", test_name, limit);
    end
    // A few more cycles to catch any store after the illegal word
    repeat (4) @(posedge clock);
    @(negedge clock);
    u_checker.finish_test(hung);
  endtask

  initial begin
    int               fd;
    int               code;
    int               count;
    int               bound;
    int               load_idx;
    bit               hung;
    bit               load_error;
    logic [8*16-1:0]  kw;
    logic [8*128-1:0] line_buf;
    logic [31:0]      word;
    logic [31:0]      addr;
    rst_n = 1'b0;
    hung = 1'b0;
    load_error = 1'b0;
    bound = 0;
    load_idx = 0;
    fd = $fopen("dv/testdata_programs.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open dv/testdata_programs.txt");
      load_error = 1'b1;
    end
    while (fd != 0 && !hung && !load_error && $fscanf(fd, "%s", kw) == 1) begin
      if (kw == "#") begin
        code = $fgets(line_buf, fd);
      end else if (kw == "test") begin
        code = $fscanf(fd, "%s %d", test_name, bound);
        @(posedge clock);
        rst_n <= 1'b0;
        fill_memory();
        load_idx = 0;
        u_checker.start_test(test_name);
      end else if (kw == "prog") begin
        code = $fscanf(fd, "%d", count);
        for (int k = 0; k < count; k++) begin
          code = $fscanf(fd, "%h", word);
          mem[load_idx] = word;
          load_idx++;
        end
      end else if (kw == "store") begin
        code = $fscanf(fd, "%h %h", addr, word);
        u_checker.add_expected(addr, word);
      end else if (kw == "end") begin
        run_test(bound, hung);
      end else begin
        $display("error: unknown keyword %0s in the test data file", kw);
        load_error = 1'b1;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    u_checker.report_counts();
    if (load_error || u_checker.tests_run == 0 || u_checker.failed_tests != 0) begin
      $display("Simulation finished: FAIL");
    end else begin
      $display("Simulation finished: PASS");
    end
    $finish;
  end

endmodule

/* dv/testdata_programs.txt */
# test <name> <instruction bound>, prog <count> <hex words loaded from address 0>
# store <hex address> <hex data> in program order, end runs the test
test alu_ops 40
prog 8 FF900093 00300113 002081B3 40208233 4020D2B3 0020D333 0020A3B3 0020B433
prog 8 0F00C493 50016513 07F0F593 00411613 4010D693 FFF0A713 FFF13793 10302023
prog 8 10402223 10502423 10602623 10702823 10802A23 10902C23 10A02E23 12B02023
prog 6 12C02223 12D02423 12E02623 12F02823 00000000 12302A23
store 00000100 FFFFFFFC
store 00000104 FFFFFFF6
store 00000108 FFFFFFFF
store 0000010C 1FFFFFFF
store 00000110 00000001
store 00000114 00000000
store 00000118 FFFFFF09
store 0000011C 00000503
store 00000120 00000079
store 00000124 00000030
store 00000128 FFFFFFFC
store 0000012C 00000001
store 00000130 00000001
end
test mem_branch 40
prog 7 FF900093 00300113 00300193 20102023 20002203 002202B3 20502223
prog 8 00310463 001A0A13 00209463 002A0A13 0020C463 004A0A13 00115463 008A0A13
prog 8 00116463 010A0A13 0020F463 020A0A13 00208463 001A8A93 00311463 002A8A93
prog 8 00114463 004A8A93 0020D463 008A8A93 0020E463 010A8A93 00117463 020A8A93
prog 4 21402423 21502623 FFFFFFFF 20502823
store 00000200 FFFFFFF9
store 00000204 FFFFFFFC
store 00000208 00000000
store 0000020C 0000003F
end
test jump_upper 24
prog 8 123450B7 00001117 00C001EF 00100213 00100213 05020213 021182E7 00120213
prog 8 00120213 00120213 00120213 00520213 30102023 30202223 30302423 30502623
prog 3 30402823 00000000 30402A23
store 00000300 12345000
store 00000304 00001004
store 00000308 0000000C
store 0000030C 0000001C
store 00000310 00000055
end

/* tb.f */
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_imm_ext.sv
rtl/rv_reg_file.sv
rtl/rv_dataflow.sv
rtl/rv_control.sv
rtl/rv_core.sv
dv/tb_checker.sv
dv/tb_top.sv

/* Bender.yml */
package:
  name: rv32i_multicycle

sources:
  - rtl/rv_pkg.sv
  - rtl/rv_alu.sv
  - rtl/rv_imm_ext.sv
  - rtl/rv_reg_file.sv
  - rtl/rv_dataflow.sv
  - rtl/rv_control.sv
  - rtl/rv_core.sv
  - target: simulation
    files:
      - dv/tb_checker.sv
      - dv/tb_top.sv
